// File: common/regfile_if.sv
// --------------------------------------------------------------------------
// Register file interface: two read ports, one write port, with modports
// for the operand reader, the writeback stage and the storage.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

`include "rv_cfg.svh"

interface regfile_if;

    // Read side.
    logic [`RV_REG_AW-1:0] rs1_addr;
    logic [`RV_REG_AW-1:0] rs2_addr;
    logic [`RV_XLEN-1:0]   rs1_data;
    logic [`RV_XLEN-1:0]   rs2_data;

    // Write side, takes effect at the rising edge with we high.
    logic                  we;
    logic [`RV_REG_AW-1:0] waddr;
    logic [`RV_XLEN-1:0]   wdata;

    modport reader (output rs1_addr, rs2_addr, input rs1_data, rs2_data);

    modport writer (output we, waddr, wdata);

    modport storage (
        input  rs1_addr, rs2_addr, we, waddr, wdata,
        output rs1_data, rs2_data
    );

endinterface

// File: common/rv_cfg.svh
// --------------------------------------------------------------------------
// Architectural sizes of the RV64I execution slice: data width, register
// count and register address width.
// --------------------------------------------------------------------------

`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Integer register and datapath width.
`define RV_XLEN 64

// Number of architectural integer registers.
`define RV_NUM_REGS 32

// Register address width.
`define RV_REG_AW 5

`endif

// File: common/rv_exec_pkg.sv
// --------------------------------------------------------------------------
// Execution slice types: ALU operation and decoded instruction.
// --------------------------------------------------------------------------

`include "rv_cfg.svh"

package rv_exec_pkg;

    // ALU operations; PASS_B forwards the second operand for LUI.
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    // ----------------------------------------------------------------------
    // Decoded instruction, produced by the decoder.
    // ----------------------------------------------------------------------

    typedef struct packed {
        alu_op_e                alu_op;
        logic [`RV_REG_AW-1:0]  rs1;
        logic [`RV_REG_AW-1:0]  rs2;
        logic [`RV_REG_AW-1:0]  rd;
        logic                   use_imm;
        logic [`RV_XLEN-1:0]    imm;
        logic                   writes_rd;
        logic                   illegal;
    } decoded_t;

endpackage

// File: common/rv_isa_pkg.sv
// --------------------------------------------------------------------------
// ISA encoding types: major opcode and funct3 minor operation codes.
// --------------------------------------------------------------------------

package rv_isa_pkg;

    // ----------------------------------------------------------------------
    // Major opcodes, instruction bits [6:0].
    // ----------------------------------------------------------------------

    // Only the opcodes the slice executes are named.
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    // ----------------------------------------------------------------------
    // Minor operation codes, instruction bits [14:12].
    // ----------------------------------------------------------------------

    // ADD and SUB share one code, funct7 tells them apart.
    // SRL and SRA likewise.
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SRL  = 3'b101,
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } funct3_e;

    // funct7 values for the R-type forms.
    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

    // Upper six bits of a 64-bit shift-immediate.
    localparam logic [5:0] FUNCT6_SRA  = 6'b010000;

endpackage

// File: design/alu.sv
// --------------------------------------------------------------------------
// 64-bit ALU: add, subtract, logic, signed and unsigned compare, shifts.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

`include "rv_cfg.svh"

module alu (
    input  rv_exec_pkg::alu_op_e i_op,
    input  logic [`RV_XLEN-1:0]  i_a,
    input  logic [`RV_XLEN-1:0]  i_b,
    output logic [`RV_XLEN-1:0]  o_result
);

    logic [5:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // RV64 shifts take the low six bits of the amount.
    assign shamt = i_b[5:0];

    assign lt_signed   = $signed(i_a) < $signed(i_b);
    assign lt_unsigned = i_a < i_b;

    always_comb begin
        case (i_op)
            rv_exec_pkg::ALU_ADD: begin
                o_result = i_a + i_b;
            end
            rv_exec_pkg::ALU_SUB: begin
                o_result = i_a - i_b;
            end
            rv_exec_pkg::ALU_SLL: begin
                o_result = i_a << shamt;
            end
            rv_exec_pkg::ALU_SLT: begin
                o_result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
            end
            rv_exec_pkg::ALU_SLTU: begin
                o_result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
            end
            rv_exec_pkg::ALU_XOR: begin
                o_result = i_a ^ i_b;
            end
            rv_exec_pkg::ALU_SRL: begin
                o_result = i_a >> shamt;
            end
            rv_exec_pkg::ALU_SRA: begin
                o_result = $unsigned($signed(i_a) >>> shamt);
            end
            rv_exec_pkg::ALU_OR: begin
                o_result = i_a | i_b;
            end
            rv_exec_pkg::ALU_AND: begin
                o_result = i_a & i_b;
            end
            default: begin
                // LUI, immediate passes straight through.
                o_result = i_b;
            end
        endcase
    end

endmodule

// File: design/register_file.sv
// --------------------------------------------------------------------------
// Integer register file: two combinational reads, one synchronous write,
// x0 hardwired to zero.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

`include "rv_cfg.svh"

module register_file (
    input logic        clk,
    input logic        arstn,
    regfile_if.storage rf
);

    // Register storage.
    logic [`RV_XLEN-1:0] mem [`RV_NUM_REGS];

    // ----------------------------------------------------------------------
    // Write port.
    // ----------------------------------------------------------------------

    // Entry 0 is cleared on reset and never written afterwards.
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                mem[i] <= '0;
            end
        end else if (rf.we && (rf.waddr != '0)) begin
            mem[rf.waddr] <= rf.wdata;
        end
    end

    // ----------------------------------------------------------------------
    // Read ports.
    // ----------------------------------------------------------------------

    // No write-through here; the writeback stage forwards.
    assign rf.rs1_data = mem[rf.rs1_addr];
    assign rf.rs2_data = mem[rf.rs2_addr];

endmodule

// File: design/rv_decoder.sv
// --------------------------------------------------------------------------
// Instruction decoder for OP-IMM, OP and LUI; flags all other encodings.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

`include "rv_cfg.svh"

module rv_decoder (
    input  logic [31:0]           i_instr,
    output rv_exec_pkg::decoded_t o_dec
);

    rv_isa_pkg::opcode_e opcode;
    rv_isa_pkg::funct3_e funct3;
    logic [6:0]          funct7;
    logic [5:0]          funct6;

    assign opcode = rv_isa_pkg::opcode_e'(i_instr[6:0]);
    assign funct3 = rv_isa_pkg::funct3_e'(i_instr[14:12]);
    assign funct7 = i_instr[31:25];
    assign funct6 = i_instr[31:26];

    always_comb begin
        o_dec         = '0;
        o_dec.alu_op  = rv_exec_pkg::ALU_ADD;
        o_dec.rs1     = i_instr[19:15];
        o_dec.rs2     = i_instr[24:20];
        o_dec.rd      = i_instr[11:7];
        o_dec.imm     = {{(`RV_XLEN-12){i_instr[31]}}, i_instr[31:20]};
        o_dec.illegal = 1'b0;

        case (opcode)
            rv_isa_pkg::OPC_OP_IMM: begin
                // I-type, rs2 field is part of the immediate.
                o_dec.use_imm = 1'b1;
                o_dec.rs2     = '0;
                case (funct3)
                    rv_isa_pkg::F3_ADD:  o_dec.alu_op = rv_exec_pkg::ALU_ADD;
                    rv_isa_pkg::F3_SLT:  o_dec.alu_op = rv_exec_pkg::ALU_SLT;
                    rv_isa_pkg::F3_SLTU: o_dec.alu_op = rv_exec_pkg::ALU_SLTU;
                    rv_isa_pkg::F3_XOR:  o_dec.alu_op = rv_exec_pkg::ALU_XOR;
                    rv_isa_pkg::F3_OR:   o_dec.alu_op = rv_exec_pkg::ALU_OR;
                    rv_isa_pkg::F3_AND:  o_dec.alu_op = rv_exec_pkg::ALU_AND;
                    rv_isa_pkg::F3_SLL: begin
                        o_dec.alu_op  = rv_exec_pkg::ALU_SLL;
                        o_dec.illegal = (funct6 != '0);
                    end
                    default: begin
                        // SRLI or SRAI, anything else in funct6 is reserved.
                        o_dec.alu_op  = (funct6 == rv_isa_pkg::FUNCT6_SRA) ?
                                        rv_exec_pkg::ALU_SRA : rv_exec_pkg::ALU_SRL;
                        o_dec.illegal = (funct6 != '0) &&
                                        (funct6 != rv_isa_pkg::FUNCT6_SRA);
                    end
                endcase
            end
            rv_isa_pkg::OPC_OP: begin
                case (funct3)
                    rv_isa_pkg::F3_ADD:  o_dec.alu_op = (funct7[5]) ?
                        rv_exec_pkg::ALU_SUB : rv_exec_pkg::ALU_ADD;
                    rv_isa_pkg::F3_SRL:  o_dec.alu_op = (funct7[5]) ?
                        rv_exec_pkg::ALU_SRA : rv_exec_pkg::ALU_SRL;
                    rv_isa_pkg::F3_SLL:  o_dec.alu_op = rv_exec_pkg::ALU_SLL;
                    rv_isa_pkg::F3_SLT:  o_dec.alu_op = rv_exec_pkg::ALU_SLT;
                    rv_isa_pkg::F3_SLTU: o_dec.alu_op = rv_exec_pkg::ALU_SLTU;
                    rv_isa_pkg::F3_XOR:  o_dec.alu_op = rv_exec_pkg::ALU_XOR;
                    rv_isa_pkg::F3_OR:   o_dec.alu_op = rv_exec_pkg::ALU_OR;
                    default:             o_dec.alu_op = rv_exec_pkg::ALU_AND;
                endcase
                // Only ADD/SUB and SRL/SRA accept the alternate funct7.
                if ((funct3 == rv_isa_pkg::F3_ADD) || (funct3 == rv_isa_pkg::F3_SRL)) begin
                    o_dec.illegal = (funct7 != rv_isa_pkg::FUNCT7_BASE) &&
                                    (funct7 != rv_isa_pkg::FUNCT7_ALT);
                end else begin
                    o_dec.illegal = (funct7 != rv_isa_pkg::FUNCT7_BASE);
                end
            end
            rv_isa_pkg::OPC_LUI: begin
                // U-type, upper 20 bits sign-extended to 64.
                o_dec.alu_op  = rv_exec_pkg::ALU_PASS_B;
                o_dec.use_imm = 1'b1;
                o_dec.rs1     = '0;
                o_dec.rs2     = '0;
                o_dec.imm     = {{(`RV_XLEN-32){i_instr[31]}}, i_instr[31:12], 12'b0};
            end
            default: o_dec.illegal = 1'b1;
        endcase

        o_dec.writes_rd = ~o_dec.illegal;
    end

endmodule

// File: design/rv_exec_top.sv
// --------------------------------------------------------------------------
// RV64I execution slice top: decoder, ALU, writeback stage, register file.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

`include "rv_cfg.svh"

module rv_exec_top (
    input  logic                  clk,
    input  logic                  arstn,
    input  logic                  i_instr_valid,
    input  logic [31:0]           i_instr,
    output logic                  o_retire_valid,
    output logic [`RV_REG_AW-1:0] o_retire_rd,
    output logic [`RV_XLEN-1:0]   o_retire_data,
    output logic                  o_illegal
);

    rv_exec_pkg::decoded_t dec;
    logic [`RV_XLEN-1:0]   op_a;
    logic [`RV_XLEN-1:0]   op_b;
    logic [`RV_XLEN-1:0]   alu_b;
    logic [`RV_XLEN-1:0]   alu_result;

    regfile_if rf ();

    rv_decoder u_decoder (
        .i_instr (i_instr),
        .o_dec   (dec)
    );

    // Operand read addresses come straight from decode.
    assign rf.rs1_addr = dec.rs1;
    assign rf.rs2_addr = dec.rs2;

    register_file u_register_file (
        .clk   (clk),
        .arstn (arstn),
        .rf    (rf.storage)
    );

    // Immediate or forwarded register operand.
    assign alu_b = dec.use_imm ? dec.imm : op_b;

    alu u_alu (
        .i_op     (dec.alu_op),
        .i_a      (op_a),
        .i_b      (alu_b),
        .o_result (alu_result)
    );

    writeback_stage u_writeback_stage (
        .clk            (clk),
        .arstn          (arstn),
        .i_valid        (i_instr_valid),
        .i_rd           (dec.rd),
        .i_result       (alu_result),
        .i_writes_rd    (dec.writes_rd),
        .i_illegal      (dec.illegal),
        .i_rs1          (dec.rs1),
        .i_rs2          (dec.rs2),
        .i_rs1_data     (rf.rs1_data),
        .i_rs2_data     (rf.rs2_data),
        .o_op_a         (op_a),
        .o_op_b         (op_b),
        .rf             (rf.writer),
        .o_retire_valid (o_retire_valid),
        .o_retire_rd    (o_retire_rd),
        .o_retire_data  (o_retire_data),
        .o_illegal      (o_illegal)
    );

endmodule

// File: design/writeback_stage.sv
// --------------------------------------------------------------------------
// Writeback register: retire outputs, register file write, operand forwarding.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

`include "rv_cfg.svh"

module writeback_stage (
    input  logic                  clk,
    input  logic                  arstn,
    input  logic                  i_valid,
    input  logic [`RV_REG_AW-1:0] i_rd,
    input  logic [`RV_XLEN-1:0]   i_result,
    input  logic                  i_writes_rd,
    input  logic                  i_illegal,
    input  logic [`RV_REG_AW-1:0] i_rs1,
    input  logic [`RV_REG_AW-1:0] i_rs2,
    input  logic [`RV_XLEN-1:0]   i_rs1_data,
    input  logic [`RV_XLEN-1:0]   i_rs2_data,
    output logic [`RV_XLEN-1:0]   o_op_a,
    output logic [`RV_XLEN-1:0]   o_op_b,
    regfile_if.writer             rf,
    output logic                  o_retire_valid,
    output logic [`RV_REG_AW-1:0] o_retire_rd,
    output logic [`RV_XLEN-1:0]   o_retire_data,
    output logic                  o_illegal
);

    logic                  valid_q;
    logic                  illegal_q;
    logic                  we_q;
    logic [`RV_REG_AW-1:0] rd_q;
    logic [`RV_XLEN-1:0]   data_q;
    logic                  fwd_a;
    logic                  fwd_b;

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            valid_q   <= 1'b0;
            illegal_q <= 1'b0;
            we_q      <= 1'b0;
        end else begin
            valid_q   <= i_valid & ~i_illegal;
            illegal_q <= i_valid & i_illegal;
            we_q      <= i_valid & i_writes_rd & ~i_illegal;
        end
    end

    // Result payload.
    always_ff @(posedge clk) begin
        if (i_valid) begin
            rd_q   <= i_rd;
            data_q <= i_result;
        end
    end

    assign rf.we    = we_q;
    assign rf.waddr = rd_q;
    assign rf.wdata = data_q;

    assign o_retire_valid = valid_q;
    assign o_retire_rd    = rd_q;
    assign o_retire_data  = data_q;
    assign o_illegal      = illegal_q;

    // Pending write not yet in the register file; x0 never forwards.
    assign fwd_a  = we_q && (rd_q != '0) && (rd_q == i_rs1);
    assign fwd_b  = we_q && (rd_q != '0) && (rd_q == i_rs2);
    assign o_op_a = fwd_a ? data_q : i_rs1_data;
    assign o_op_b = fwd_b ? data_q : i_rs2_data;

endmodule

// File: run_sim.sh
#!/bin/sh
# Compiles the RV64I execution slice testbench with Verilator and runs it.
# Exits with status 0 only when the run reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module rv_exec_tb -f rv_exec.f -o rv_exec_sim || exit 1

sim_out="$(./obj_dir/rv_exec_sim 2>&1)"
echo "$sim_out"
echo "$sim_out" | grep -q "SIMULATION PASSED" && exit 0 || exit 1

// File: rv_exec.f
+incdir+common
common/rv_isa_pkg.sv
common/rv_exec_pkg.sv
common/regfile_if.sv
design/rv_decoder.sv
design/register_file.sv
design/alu.sv
design/writeback_stage.sv
design/rv_exec_top.sv
tests/rv_exec_assertions.sv
tests/rv_exec_tb.sv

// File: tests/rv_exec_assertions.sv
// --------------------------------------------------------------------------
// Concurrent assertions bound into every writeback stage instance.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

`include "rv_cfg.svh"

module rv_exec_assertions (
    input logic                  clk,
    input logic                  arstn,
    input logic                  i_retire_valid,
    input logic                  i_illegal,
    input logic                  i_we,
    input logic [`RV_REG_AW-1:0] i_rs1,
    input logic [`RV_REG_AW-1:0] i_rs2,
    input logic [`RV_XLEN-1:0]   i_op_a,
    input logic [`RV_XLEN-1:0]   i_op_b
);

    // Every legal retirement writes the register file, x0 included.
    retire_writes_reg : assert property (@(posedge clk) disable iff (!arstn)
        i_retire_valid == i_we)
        else $error("retire valid and register write enable differ");

    // x0 operands stay zero whatever was written to x0.
    x0_read_a : assert property (@(posedge clk) disable iff (!arstn)
        (i_rs1 == '0) |-> (i_op_a == '0))
        else $error("x0 read on operand a is not zero");

    x0_read_b : assert property (@(posedge clk) disable iff (!arstn)
        (i_rs2 == '0) |-> (i_op_b == '0))
        else $error("x0 read on operand b is not zero");

    // Quiet outputs in reset.
    quiet_in_reset : assert property (@(posedge clk)
        !arstn |-> (!i_retire_valid && !i_illegal && !i_we))
        else $error("outputs active during reset");

endmodule

bind writeback_stage rv_exec_assertions u_rv_exec_assertions (
    .clk            (clk),
    .arstn          (arstn),
    .i_retire_valid (o_retire_valid),
    .i_illegal      (o_illegal),
    .i_we           (we_q),
    .i_rs1          (i_rs1),
    .i_rs2          (i_rs2),
    .i_op_a         (o_op_a),
    .i_op_b         (o_op_b)
);

// File: tests/rv_exec_tb.sv
// --------------------------------------------------------------------------
// Testbench for the RV64I execution slice: directed and random instructions,
// reference model, retire comparison, watchdog and report.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

`include "rv_cfg.svh"

module rv_exec_tb;

    localparam int NUM_RANDOM      = 400;
    localparam int MAX_GAP         = 2;
    localparam int DIRECTED_CYCLES = 300;
    // Reset, directed budget and worst-case random length in 4 ns cycles.
    localparam int WATCHDOG_NS     = 4 * (16 + DIRECTED_CYCLES + NUM_RANDOM * (MAX_GAP + 1)) + 400;

    logic                  clk;
    logic                  arstn;
    logic                  i_instr_valid;
    logic [31:0]           i_instr;
    logic                  o_retire_valid;
    logic [`RV_REG_AW-1:0] o_retire_rd;
    logic [`RV_XLEN-1:0]   o_retire_data;
    logic                  o_illegal;

    // Expected retirement of one issued instruction.
    typedef struct packed {
        logic                  illegal;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   data;
    } expect_t;

    logic [`RV_XLEN-1:0] model_regs [`RV_NUM_REGS];
    expect_t             exp_q [$];
    int                  issued       = 0;
    int                  checked      = 0;
    int                  err_count    = 0;
    int                  tests_run    = 0;
    int                  tests_failed = 0;

    rv_exec_top dut (
        .clk            (clk),
        .arstn          (arstn),
        .i_instr_valid  (i_instr_valid),
        .i_instr        (i_instr),
        .o_retire_valid (o_retire_valid),
        .o_retire_rd    (o_retire_rd),
        .o_retire_data  (o_retire_data),
        .o_illegal      (o_illegal)
    );

    always #2 clk = ~clk;

    // ----------------------------------------------------------------------
    // Instruction encoders.
    // ----------------------------------------------------------------------

    function automatic logic [31:0] enc_i(rv_isa_pkg::funct3_e f3, logic [4:0] rd,
                                          logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, rv_isa_pkg::OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, rv_isa_pkg::funct3_e f3,
                                          logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] enc_u(logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, rv_isa_pkg::OPC_LUI};
    endfunction

    // ----------------------------------------------------------------------
    // Reference model.
    // ----------------------------------------------------------------------

    function automatic logic ref_illegal(logic [31:0] instr);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        opc = instr[6:0];
        f3  = instr[14:12];
        f7  = instr[31:25];
        if (opc == rv_isa_pkg::OPC_LUI) begin
            return 1'b0;
        end
        if (opc == rv_isa_pkg::OPC_OP_IMM) begin
            if (f3 == rv_isa_pkg::F3_SLL) begin
                return instr[31:26] != 6'b000000;
            end
            if (f3 == rv_isa_pkg::F3_SRL) begin
                return (instr[31:26] != 6'b000000) && (instr[31:26] != 6'b010000);
            end
            return 1'b0;
        end
        if (opc == rv_isa_pkg::OPC_OP) begin
            if (f7 == 7'b0000000) begin
                return 1'b0;
            end
            // SUB and SRA are the only alternate forms.
            return !((f7 == 7'b0100000) &&
                     ((f3 == rv_isa_pkg::F3_ADD) || (f3 == rv_isa_pkg::F3_SRL)));
        end
        return 1'b1;
    endfunction

    function automatic logic [`RV_XLEN-1:0] ref_result(logic [31:0] instr);
        logic [`RV_XLEN-1:0]        a;
        logic [`RV_XLEN-1:0]        b;
        logic signed [`RV_XLEN-1:0] sa;
        logic [`RV_XLEN-1:0]        res;
        logic [5:0]                 sh;
        a   = model_regs[instr[19:15]];
        sa  = a;
        res = '0;
        if (instr[6:0] == rv_isa_pkg::OPC_OP_IMM) begin
            b  = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
            sh = instr[25:20];
        end else begin
            b  = model_regs[instr[24:20]];
            sh = b[5:0];
        end
        if (instr[6:0] == rv_isa_pkg::OPC_LUI) begin
            res = {{(`RV_XLEN-32){instr[31]}}, instr[31:12], 12'b0};
        end else begin
            case (instr[14:12])
                rv_isa_pkg::F3_ADD: begin
                    if ((instr[6:0] == rv_isa_pkg::OPC_OP) && instr[30]) begin
                        res = a - b;
                    end else begin
                        res = a + b;
                    end
                end
                rv_isa_pkg::F3_SLL:  res = a << sh;
                rv_isa_pkg::F3_SLT:  res = {63'b0, $signed(a) < $signed(b)};
                rv_isa_pkg::F3_SLTU: res = {63'b0, a < b};
                rv_isa_pkg::F3_XOR:  res = a ^ b;
                rv_isa_pkg::F3_OR:   res = a | b;
                rv_isa_pkg::F3_AND:  res = a & b;
                default: begin
                    if (instr[30]) begin
                        res = sa >>> sh;
                    end else begin
                        res = a >> sh;
                    end
                end
            endcase
        end
        return res;
    endfunction

    // Random word biased toward legal forms and low registers.
    function automatic logic [31:0] random_instr();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        int          kind;
        rd   = 5'($urandom_range(0, 7));
        rs1  = 5'($urandom_range(0, 7));
        rs2  = 5'($urandom_range(0, 7));
        f3   = 3'($urandom_range(0, 7));
        imm  = 12'($urandom);
        kind = $urandom_range(0, 9);
        case (kind)
            0, 1, 2, 3: begin
                if ((f3 == rv_isa_pkg::F3_SLL) || (f3 == rv_isa_pkg::F3_SRL)) begin
                    imm[11:6] = ($urandom_range(0, 1) == 0) ? 6'b0 : rv_isa_pkg::FUNCT6_SRA;
                end
                return {imm, rs1, f3, rd, rv_isa_pkg::OPC_OP_IMM};
            end
            4, 5, 6, 7: begin
                f7 = ($urandom_range(0, 1) == 0) ? rv_isa_pkg::FUNCT7_BASE
                                                 : rv_isa_pkg::FUNCT7_ALT;
                return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
            end
            8:       return {20'($urandom), rd, rv_isa_pkg::OPC_LUI};
            default: return $urandom;
        endcase
    endfunction

    // ----------------------------------------------------------------------
    // Driver tasks.
    // ----------------------------------------------------------------------

    task automatic issue(logic [31:0] instr);
        expect_t e;
        @(posedge clk);
        #1;
        i_instr_valid = 1'b1;
        i_instr       = instr;
        e.illegal     = ref_illegal(instr);
        e.rd          = instr[11:7];
        e.data        = ref_result(instr);
        if (!e.illegal && (e.rd != '0)) begin
            model_regs[e.rd] = e.data;
        end
        exp_q.push_back(e);
        issued++;
    endtask

    task automatic idle(int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            i_instr_valid = 1'b0;
            i_instr       = 32'h0;
        end
    endtask

    // Waits until every issued instruction has been compared.
    task automatic finish_test(string name, int errs_before);
        idle(1);
        while (checked != issued) begin
            @(posedge clk);
        end
        tests_run++;
        if (err_count == errs_before) begin
            $display("Test %s: done, no errors", name);
        end else begin
            tests_failed++;
            $display("Test %s: done, %0d errors", name, err_count - errs_before);
        end
    endtask

    // ----------------------------------------------------------------------
    // Retire comparison.
    // ----------------------------------------------------------------------

    always begin : compare_retire
        expect_t e;
        logic    have;
        @(posedge clk);
        have = 1'b0;
        if (arstn && i_instr_valid) begin
            if (exp_q.size() == 0) begin
                $display("Compare: instruction accepted with no expected result queued");
                err_count++;
            end else begin
                e    = exp_q.pop_front();
                have = 1'b1;
            end
        end
        @(negedge clk);
        if (have) begin
            if (e.illegal) begin
                assert (o_illegal && !o_retire_valid) else begin
                    $display("Error: time %0t, illegal pulse expected, got illegal %0b valid %0b",
                             $time, o_illegal, o_retire_valid);
                    err_count++;
                end
            end else begin
                assert (o_retire_valid && !o_illegal && (o_retire_rd == e.rd) &&
                        (o_retire_data == e.data)) else begin
                    $display({"Error: time %0t, expected rd %0d data %h, ",
                              "got valid %0b rd %0d data %h"},
                             $time, e.rd, e.data, o_retire_valid, o_retire_rd, o_retire_data);
                    err_count++;
                end
            end
            checked++;
        end else if (arstn) begin
            assert (!o_retire_valid && !o_illegal) else begin
                $display("Error: time %0t, retire or illegal output high with no instruction",
                         $time);
                err_count++;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Test sequence.
    // ----------------------------------------------------------------------

    initial begin : main
        int errs;
        int gap;
        clk           = 1'b0;
        arstn         = 1'b0;
        i_instr_valid = 1'b0;
        i_instr       = 32'h0;
        for (int r = 0; r < `RV_NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        void'($urandom(61265));
        repeat (16) @(posedge clk);
        #1;
        arstn = 1'b1;

        // Idle after reset and then x0 + x0.
        errs = err_count;
        idle(6);
        issue(enc_r(rv_isa_pkg::FUNCT7_BASE, rv_isa_pkg::F3_ADD, 5, 0, 0));
        finish_test("reset_idle", errs);

        // Immediates, compares and all shift kinds.
        errs = err_count;
        issue(enc_u(1, 20'h12345));
        issue(enc_i(rv_isa_pkg::F3_ADD, 1, 1, 12'h678));
        issue(enc_u(2, 20'h80000));
        issue(enc_i(rv_isa_pkg::F3_ADD, 2, 2, 12'hfff));
        issue(enc_i(rv_isa_pkg::F3_ADD, 3, 0, 12'h800));
        issue(enc_i(rv_isa_pkg::F3_SLT, 4, 3, 12'h001));
        issue(enc_i(rv_isa_pkg::F3_SLTU, 5, 3, 12'h001));
        issue(enc_i(rv_isa_pkg::F3_SLTU, 6, 1, 12'hfff));
        issue(enc_i(rv_isa_pkg::F3_SLT, 7, 1, 12'hfff));
        issue(enc_i(rv_isa_pkg::F3_XOR, 8, 1, 12'haaa));
        issue(enc_i(rv_isa_pkg::F3_OR, 9, 3, 12'h0f0));
        issue(enc_i(rv_isa_pkg::F3_AND, 10, 2, 12'h7ff));
        issue(enc_i(rv_isa_pkg::F3_SLL, 11, 1, {6'b0, 6'd40}));
        issue(enc_i(rv_isa_pkg::F3_SRL, 12, 2, {6'b0, 6'd13}));
        issue(enc_i(rv_isa_pkg::F3_SRL, 13, 2, {rv_isa_pkg::FUNCT6_SRA, 6'd63}));
        issue(enc_i(rv_isa_pkg::F3_SRL, 14, 3, {rv_isa_pkg::FUNCT6_SRA, 6'd4}));
        issue(enc_i(rv_isa_pkg::F3_SLL, 15, 2, {6'b0, 6'd63}));
        finish_test("op_imm", errs);

        // Each instruction reads the previous destination.
        errs = err_count;
        issue(enc_r(rv_isa_pkg::FUNCT7_BASE, rv_isa_pkg::F3_ADD, 16, 1, 2));
        issue(enc_r(rv_isa_pkg::FUNCT7_ALT, rv_isa_pkg::F3_ADD, 17, 16, 1));
        issue(enc_r(rv_isa_pkg::FUNCT7_BASE, rv_isa_pkg::F3_XOR, 18, 17, 16));
        issue(enc_r(rv_isa_pkg::FUNCT7_BASE, rv_isa_pkg::F3_SLL, 19, 18, 4));
        issue(enc_r(rv_isa_pkg::FUNCT7_BASE, rv_isa_pkg::F3_SRL, 20, 19, 11));
        issue(enc_r(rv_isa_pkg::FUNCT7_ALT, rv_isa_pkg::F3_SRL, 21, 2, 20));
        issue(enc_r(rv_isa_pkg::FUNCT7_BASE, rv_isa_pkg::F3_SLT, 22, 21, 20));
        issue(enc_r(rv_isa_pkg::FUNCT7_BASE, rv_isa_pkg::F3_SLTU, 23, 21, 22));
        issue(enc_r(rv_isa_pkg::FUNCT7_BASE, rv_isa_pkg::F3_OR, 24, 23, 21));
        issue(enc_r(rv_isa_pkg::FUNCT7_BASE, rv_isa_pkg::F3_AND, 25, 24, 24));
        issue(enc_r(rv_isa_pkg::FUNCT7_BASE, rv_isa_pkg::F3_ADD, 25, 25, 25));
        finish_test("forwarding", errs);

        // Writes to x0 followed at once by x0 reads.
        errs = err_count;
        issue(enc_i(rv_isa_pkg::F3_ADD, 0, 1, 12'd77));
        issue(enc_r(rv_isa_pkg::FUNCT7_BASE, rv_isa_pkg::F3_ADD, 26, 0, 0));
        issue(enc_r(rv_isa_pkg::FUNCT7_BASE, rv_isa_pkg::F3_OR, 0, 1, 2));
        issue(enc_r(rv_isa_pkg::FUNCT7_BASE, rv_isa_pkg::F3_OR, 27, 0, 1));
        issue(enc_u(0, 20'hfffff));
        issue(enc_i(rv_isa_pkg::F3_OR, 28, 0, 12'h000));
        finish_test("x0_writes", errs);

        // ADDIW, ADDW, LD, BEQ, MUL, alternate XOR, reserved shift, all zero.
        errs = err_count;
        issue({12'd5, 5'd1, 3'b000, 5'd10, 7'b0011011});
        issue({7'b0, 5'd2, 5'd1, 3'b000, 5'd10, 7'b0111011});
        issue({12'd8, 5'd1, 3'b011, 5'd11, 7'b0000011});
        issue({7'b0, 5'd2, 5'd1, 3'b000, 5'd0, 7'b1100011});
        issue(enc_r(7'b0000001, rv_isa_pkg::F3_ADD, 12, 1, 2));
        issue(enc_r(rv_isa_pkg::FUNCT7_ALT, rv_isa_pkg::F3_XOR, 13, 1, 2));
        issue(enc_i(rv_isa_pkg::F3_SLL, 14, 1, {6'b000001, 6'd3}));
        issue(32'h0);
        // Read every register back unchanged.
        for (int r = 1; r < `RV_NUM_REGS; r++) begin
            issue(enc_r(rv_isa_pkg::FUNCT7_BASE, rv_isa_pkg::F3_ADD, 5'(r), 5'(r), 0));
        end
        finish_test("illegal", errs);

        errs = err_count;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            gap = $urandom_range(0, MAX_GAP);
            if (gap != 0) begin
                idle(gap);
            end
            issue(random_instr());
        end
        finish_test("random", errs);

        $display("Tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule
